//--- Makefile
# Verilator build and run for the audio DAC path
TOP := snd_dac_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "^Test passed$$" sim.log || (echo "simulation did not pass, see sim.log" && exit 1)

clean:
	rm -rf obj_dir sim.log

//--- files.f
snd_dac_pkg.sv
snd_timebase.sv
snd_mute_ctrl.sv
snd_sample_cond.sv
snd_sigma_delta.sv
snd_dac_top.sv
tb_clk_gen.sv
snd_dac_tb.sv

//--- snd_dac_pkg.sv
package snd_dac_pkg;

    // Input sound sample width
    localparam int SND_W = 16;

    // Modulator input word, one guard bit above the padded sample
    localparam int PCM_W = 20;

    // Soft mute gain, 16 means unity
    localparam int GAIN_W = 5;
    localparam logic [GAIN_W-1:0] GAIN_MAX = 5'd16;

    // One sample word seen either as two's complement or as offset binary
    typedef union packed {
        logic signed [SND_W-1:0] tc;
        logic        [SND_W-1:0] ob;
    } snd_sample_u;

endpackage

//--- snd_dac_tb.sv
`timescale 1ns/1ps

module snd_dac_tb;

    localparam int CEN_DIV  = 4;
    localparam int RAMP_DIV = 8;
    localparam int SETTLE   = 4 * CEN_DIV;
    localparam int TOL      = 2 * CEN_DIV;
    localparam int RST_CYC  = 16;
    localparam int MAX_VEC  = 32;
    // Full gain ramp plus one enable period
    localparam int RAMP_CYC = 16 * RAMP_DIV * CEN_DIV + CEN_DIV;

    logic        clk_dac;
    logic        rst;
    logic [15:0] snd_left;
    logic [15:0] snd_right;
    logic        mute;
    logic        snd_pwm_left;
    logic        snd_pwm_right;
    logic        snd_active;

    // Vector table
    logic [8*24-1:0] v_name  [MAX_VEC];
    logic [15:0]     v_left  [MAX_VEC];
    logic [15:0]     v_right [MAX_VEC];
    logic            v_mute  [MAX_VEC];
    int              v_n     [MAX_VEC];
    int              v_wait  [MAX_VEC];
    int              v_exp_l [MAX_VEC];
    int              v_exp_r [MAX_VEC];
    int              num_vec;

    int run_limit;
    int cycle_cnt;

    tb_clk_gen #(
        .HALF_NS ( 4 )
    ) u_clk_gen (
        .clk_o ( clk_dac )
    );

    snd_dac_top #(
        .SIGNED_SND ( 1'b1     ),
        .STEREO     ( 1'b1     ),
        .CEN_DIV    ( CEN_DIV  ),
        .RAMP_DIV   ( RAMP_DIV )
    ) u_snd_dac_top (
        .clk_dac         ( clk_dac       ),
        .rst             ( rst           ),
        .snd_left_i      ( snd_left      ),
        .snd_right_i     ( snd_right     ),
        .mute_i          ( mute          ),
        .snd_pwm_left_o  ( snd_pwm_left  ),
        .snd_pwm_right_o ( snd_pwm_right ),
        .snd_active_o    ( snd_active    )
    );

    // Run limit from the total window length and four ramp times
    always @(posedge clk_dac) begin
        cycle_cnt <= cycle_cnt + 1;
        if (run_limit > 0 && cycle_cnt > run_limit) begin
            $display("run did not finish within %0d clock cycles", run_limit);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic read_vectors();
        int    fd;
        int    fields;
        int    total_n;
        string line;
        logic [8*24-1:0] name;
        logic [15:0]     left;
        logic [15:0]     right;
        int              mute_v;
        int              n;
        int              wait_v;
        int              exp_l;
        int              exp_r;
        num_vec = 0;
        total_n = 0;
        fd = $fopen("snd_dac_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open snd_dac_vectors.txt");
            $display("Test failed");
            $fatal(1);
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] != "#") begin
                    fields = $sscanf(line, "%s %h %h %d %d %d %d %d", name, left, right,
                                     mute_v, n, wait_v, exp_l, exp_r);
                    if (fields == 8 && num_vec < MAX_VEC) begin
                        v_name[num_vec]  = name;
                        v_left[num_vec]  = left;
                        v_right[num_vec] = right;
                        v_mute[num_vec]  = (mute_v != 0);
                        v_n[num_vec]     = n;
                        v_wait[num_vec]  = wait_v;
                        v_exp_l[num_vec] = exp_l;
                        v_exp_r[num_vec] = exp_r;
                        total_n          = total_n + n;
                        num_vec          = num_vec + 1;
                    end
                end
            end
            $fclose(fd);
            run_limit = total_n + 4 * RAMP_CYC;
        end
    endtask

    // Polls snd_active_o between edges, gives up after max_cyc clocks
    task automatic wait_for_active(input logic level, input int max_cyc);
        int waited;
        waited = 0;
        while (snd_active !== level && waited < max_cyc) begin
            @(negedge clk_dac);
            waited = waited + 1;
        end
        assert (snd_active === level) else begin
            $display("snd_active_o did not reach %0b within %0d cycles", level, max_cyc);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic count_high(input int n, output int cnt_l, output int cnt_r);
        cnt_l = 0;
        cnt_r = 0;
        repeat (n) begin
            @(negedge clk_dac);
            if (snd_pwm_left) cnt_l = cnt_l + 1;
            if (snd_pwm_right) cnt_r = cnt_r + 1;
        end
    endtask

    task automatic check_count(input logic [8*24-1:0] name, input string chan,
                               input int expected, input int actual);
        assert (actual >= expected - TOL && actual <= expected + TOL) else begin
            $display("mismatch %0s %0s expected %0d actual %0d", name, chan, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic apply_step(input int i);
        int cnt_l;
        int cnt_r;
        snd_dac_pkg::snd_sample_u s_l;
        snd_dac_pkg::snd_sample_u s_r;
        s_l = v_left[i];
        s_r = v_right[i];
        $display("step %0s left %0d right %0d mute %0b", v_name[i], s_l.tc, s_r.tc, v_mute[i]);
        @(posedge clk_dac);
        snd_left  <= v_left[i];
        snd_right <= v_right[i];
        mute      <= v_mute[i];
        case (v_wait[i])
            1: wait_for_active(1'b1, RAMP_CYC + 2);
            2: begin
                wait_for_active(1'b0, RAMP_CYC + 2);
                // Gain still has to ramp down to zero
                repeat (RAMP_CYC) @(negedge clk_dac);
            end
            default: ;
        endcase
        repeat (SETTLE) @(negedge clk_dac);
        count_high(v_n[i], cnt_l, cnt_r);
        check_count(v_name[i], "left", v_exp_l[i], cnt_l);
        check_count(v_name[i], "right", v_exp_r[i], cnt_r);
    endtask

    initial begin
        rst       = 1'b1;
        snd_left  = '0;
        snd_right = '0;
        mute      = 1'b1;
        cycle_cnt = 0;
        run_limit = 0;
        read_vectors();
        assert (num_vec > 0) else begin
            $display("no test steps found in snd_dac_vectors.txt");
            $display("Test failed");
            $fatal(1);
        end
        repeat (RST_CYC) @(posedge clk_dac);
        rst <= 1'b0;
        @(negedge clk_dac);
        assert (snd_active === 1'b0) else begin
            $display("snd_active_o high right after reset");
            $display("Test failed");
            $fatal(1);
        end
        for (int i = 0; i < num_vec; i++) begin
            apply_step(i);
        end
        $display("Test passed");
        $finish;
    end

endmodule

//--- snd_dac_top.sv
`timescale 1ns/1ps

module snd_dac_top #(
    parameter bit          SIGNED_SND = 1'b1,
    parameter bit          STEREO     = 1'b1,
    parameter int unsigned CEN_DIV    = 4,
    parameter int unsigned RAMP_DIV   = 8
) (
    input  logic                          clk_dac,
    input  logic                          rst,
    input  logic [snd_dac_pkg::SND_W-1:0] snd_left_i,
    input  logic [snd_dac_pkg::SND_W-1:0] snd_right_i,
    input  logic                          mute_i,
    output logic                          snd_pwm_left_o,
    output logic                          snd_pwm_right_o,
    output logic                          snd_active_o
);

    logic                           cen;
    logic                           ramp_tick;
    logic [snd_dac_pkg::GAIN_W-1:0] gain;
    logic [snd_dac_pkg::PCM_W-1:0]  pcm_left;

    snd_timebase #(
        .CEN_DIV  ( CEN_DIV  ),
        .RAMP_DIV ( RAMP_DIV )
    ) u_timebase (
        .clk_dac     ( clk_dac   ),
        .rst         ( rst       ),
        .cen_o       ( cen       ),
        .ramp_tick_o ( ramp_tick )
    );

    // One gain shared by both channels
    snd_mute_ctrl u_mute_ctrl (
        .clk_dac      ( clk_dac      ),
        .rst          ( rst          ),
        .mute_i       ( mute_i       ),
        .ramp_tick_i  ( ramp_tick    ),
        .gain_o       ( gain         ),
        .snd_active_o ( snd_active_o )
    );

    snd_sample_cond #(
        .SIGNED_SND ( SIGNED_SND )
    ) u_cond_left (
        .clk_dac ( clk_dac    ),
        .rst     ( rst        ),
        .cen_i   ( cen        ),
        .snd_i   ( snd_left_i ),
        .gain_i  ( gain       ),
        .pcm_o   ( pcm_left   )
    );

    snd_sigma_delta u_sd_left (
        .clk_dac ( clk_dac        ),
        .rst     ( rst            ),
        .cen_i   ( cen            ),
        .pcm_i   ( pcm_left       ),
        .dac_o   ( snd_pwm_left_o )
    );

    if (STEREO) begin : g_stereo
        logic [snd_dac_pkg::PCM_W-1:0] pcm_right;

        snd_sample_cond #(
            .SIGNED_SND ( SIGNED_SND )
        ) u_cond_right (
            .clk_dac ( clk_dac     ),
            .rst     ( rst         ),
            .cen_i   ( cen         ),
            .snd_i   ( snd_right_i ),
            .gain_i  ( gain        ),
            .pcm_o   ( pcm_right   )
        );

        snd_sigma_delta u_sd_right (
            .clk_dac ( clk_dac         ),
            .rst     ( rst             ),
            .cen_i   ( cen             ),
            .pcm_i   ( pcm_right       ),
            .dac_o   ( snd_pwm_right_o )
        );
    end else begin : g_mono
        // Mono games drive both speakers from the left channel
        assign snd_pwm_right_o = snd_pwm_left_o;
    end

endmodule

//--- snd_dac_vectors.txt
# name left_hex right_hex mute window_clocks wait exp_left exp_right
# wait 0 settle only, 1 until snd_active_o high, 2 until low plus ramp; counts are u*N/2^17
reset_mid    7fff 8000 1 4096 0 1024 1024
unmute_full  7fff 7fff 0 4096 1 2048 2048
neg_half     c000 c000 0 4096 0 512 512
pos_half     4000 4000 0 4096 0 1536 1536
sign_max     7fff 7fff 0 2048 0 1024 1024
sign_min     8000 8000 0 4096 0 0 0
sign_zero    0000 0000 0 4096 0 1024 1024
stereo_split 2000 e000 0 4096 0 1280 768
stereo_swap  e000 2000 0 4096 0 768 1280
mute_mid     4000 c000 1 4096 2 1024 1024

//--- snd_mute_ctrl.sv
`timescale 1ns/1ps

module snd_mute_ctrl (
    input  logic                           clk_dac,
    input  logic                           rst,
    input  logic                           mute_i,
    input  logic                           ramp_tick_i,
    output logic [snd_dac_pkg::GAIN_W-1:0] gain_o,
    output logic                           snd_active_o
);

    typedef enum logic [1:0] {
        SILENT,
        RAMP_UP,
        PLAYING,
        RAMP_DOWN
    } state_t;

    state_t                         state_q;
    logic [snd_dac_pkg::GAIN_W-1:0] gain_q;
    logic [snd_dac_pkg::GAIN_W-1:0] gain_up;
    logic [snd_dac_pkg::GAIN_W-1:0] gain_dn;

    assign gain_up = gain_q + 1'b1;
    assign gain_dn = gain_q - 1'b1;

    assign gain_o       = gain_q;
    assign snd_active_o = (state_q == PLAYING);

    // Gain moves one step per ramp tick, direction follows mute_i
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            state_q <= SILENT;
            gain_q  <= '0;
        end else if (ramp_tick_i) begin
            case (state_q)
                SILENT: begin
                    if (!mute_i) begin
                        gain_q  <= gain_up;
                        state_q <= (gain_up == snd_dac_pkg::GAIN_MAX) ? PLAYING : RAMP_UP;
                    end
                end
                PLAYING: begin
                    if (mute_i) begin
                        gain_q  <= gain_dn;
                        state_q <= (gain_dn == '0) ? SILENT : RAMP_DOWN;
                    end
                end
                default: begin
                    // Mid-ramp, a change of mute_i simply reverses the step
                    if (mute_i) begin
                        gain_q  <= gain_dn;
                        state_q <= (gain_dn == '0) ? SILENT : RAMP_DOWN;
                    end else begin
                        gain_q  <= gain_up;
                        state_q <= (gain_up == snd_dac_pkg::GAIN_MAX) ? PLAYING : RAMP_UP;
                    end
                end
            endcase
        end
    end

    a_gain_limit: assert property (
        @(posedge clk_dac) disable iff (rst) gain_q <= snd_dac_pkg::GAIN_MAX
    ) else $error("mute gain above unity");

    a_gain_on_tick: assert property (
        @(posedge clk_dac) disable iff (rst) !ramp_tick_i |=> $stable(gain_q)
    ) else $error("mute gain changed without a ramp tick");

endmodule

//--- snd_sample_cond.sv
`timescale 1ns/1ps

module snd_sample_cond #(
    parameter bit SIGNED_SND = 1'b1
) (
    input  logic                           clk_dac,
    input  logic                           rst,
    input  logic                           cen_i,
    input  logic [snd_dac_pkg::SND_W-1:0]  snd_i,
    input  logic [snd_dac_pkg::GAIN_W-1:0] gain_i,
    output logic [snd_dac_pkg::PCM_W-1:0]  pcm_o
);

    localparam int SND_W  = snd_dac_pkg::SND_W;
    localparam int PROD_W = SND_W + snd_dac_pkg::GAIN_W + 2;

    snd_dac_pkg::snd_sample_u  samp;
    logic [SND_W-1:0]          offset_w;
    logic signed [SND_W:0]     centred;
    logic signed [PROD_W-1:0]  product;
    logic signed [PROD_W-1:0]  scaled;
    logic [SND_W-1:0]          u_w;
    logic [snd_dac_pkg::PCM_W-1:0] pcm_q;

    always_comb begin
        samp = snd_i;
        // Offset binary form, top bit flipped for signed input
        offset_w = {samp.ob[SND_W-1] ^ SIGNED_SND, samp.ob[SND_W-2:0]};
        // Signed distance from midscale
        centred = $signed({1'b0, offset_w}) - 17'sd32768;
        product = centred * $signed({1'b0, gain_i});
        // Arithmetic shift floors towards minus infinity
        scaled = (product >>> 4) + PROD_W'(32768);
        u_w    = scaled[SND_W-1:0];
    end

    // Guard bit on top, three zero bits below
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            pcm_q <= '0;
        end else if (cen_i) begin
            pcm_q <= {1'b0, u_w, 3'b000};
        end
    end

    assign pcm_o = pcm_q;

endmodule

//--- snd_sigma_delta.sv
`timescale 1ns/1ps

module snd_sigma_delta (
    input  logic                          clk_dac,
    input  logic                          rst,
    input  logic                          cen_i,
    input  logic [snd_dac_pkg::PCM_W-1:0] pcm_i,
    output logic                          dac_o
);

    localparam int PCM_W = snd_dac_pkg::PCM_W;

    logic [PCM_W-1:0] acc_q;
    logic [PCM_W:0]   sum;
    logic             dac_q;

    // Carry out of the accumulator is the one-bit output
    assign sum = {1'b0, acc_q} + {1'b0, pcm_i};

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            acc_q <= '0;
            dac_q <= 1'b0;
        end else if (cen_i) begin
            acc_q <= sum[PCM_W-1:0];
            dac_q <= sum[PCM_W];
        end
    end

    assign dac_o = dac_q;

    // Guard bit clear keeps the one-density at or below half
    a_guard_clear: assert property (
        @(posedge clk_dac) disable iff (rst) cen_i |-> !pcm_i[PCM_W-1]
    ) else $error("PCM guard bit set at modulator input");

endmodule

//--- snd_timebase.sv
`timescale 1ns/1ps

module snd_timebase #(
    parameter int unsigned CEN_DIV  = 4,
    parameter int unsigned RAMP_DIV = 8
) (
    input  logic clk_dac,
    input  logic rst,
    output logic cen_o,
    output logic ramp_tick_o
);

    localparam int RCNT_W = (RAMP_DIV > 1) ? $clog2(RAMP_DIV) : 1;

    logic [CEN_DIV-1:0] ring_q;
    logic [RCNT_W-1:0]  rcnt_q;
    logic               ramp_last;

    // A single hot bit walks upwards and wraps into bit 0
    assign cen_o = ring_q[0];

    assign ramp_last   = (rcnt_q == RCNT_W'(RAMP_DIV - 1));
    assign ramp_tick_o = cen_o & ramp_last;

    // Starting at bit 1 puts the first strobe CEN_DIV-1 clocks after reset
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            ring_q <= CEN_DIV'(2);
        end else begin
            ring_q <= {ring_q[CEN_DIV-2:0], ring_q[CEN_DIV-1]};
        end
    end

    // Counts enables within one gain step
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            rcnt_q <= '0;
        end else if (cen_o) begin
            if (ramp_last) begin
                rcnt_q <= '0;
            end else begin
                rcnt_q <= rcnt_q + 1'b1;
            end
        end
    end

    if (CEN_DIV < 2) begin : g_bad_div
        $error("snd_timebase needs CEN_DIV of at least 2");
    end

    a_ring_onehot: assert property (
        @(posedge clk_dac) disable iff (rst) $onehot(ring_q)
    ) else $error("cen ring lost its single hot bit");

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_NS = 4
) (
    output logic clk_o
);

    // 8 ns period with the default half period
    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(HALF_NS) clk_o = ~clk_o;
    end

endmodule
